// ==== src/riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

  localparam int XLEN         = 64;
  localparam int REG_IDX_W    = 5;
  // shift amount widths for full and word forms.
  localparam int SHAMT_W      = 6;
  localparam int SHAMT_WORD_W = 5;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [3:0]           alu_op_t;
  typedef logic [2:0]           branch_op_t;
  typedef logic [2:0]           load_op_t;
  typedef logic [3:0]           store_len_t;
  typedef logic [3:0]           wb_sel_t;

  // alu operation codes.
  localparam alu_op_t ALU_ADD   = 4'd0;
  localparam alu_op_t ALU_SUB   = 4'd1;
  localparam alu_op_t ALU_SLL   = 4'd2;
  localparam alu_op_t ALU_SLT   = 4'd3;
  localparam alu_op_t ALU_SLTU  = 4'd4;
  localparam alu_op_t ALU_XOR   = 4'd5;
  localparam alu_op_t ALU_SRL   = 4'd6;
  localparam alu_op_t ALU_SRA   = 4'd7;
  localparam alu_op_t ALU_OR    = 4'd8;
  localparam alu_op_t ALU_AND   = 4'd9;
  // passes operand 2 through, used by lui.
  localparam alu_op_t ALU_PASSB = 4'd10;

  // branch codes, same as funct3 of the B-type instructions.
  localparam branch_op_t BR_EQ  = 3'b000;
  localparam branch_op_t BR_NE  = 3'b001;
  localparam branch_op_t BR_LT  = 3'b100;
  localparam branch_op_t BR_GE  = 3'b101;
  localparam branch_op_t BR_LTU = 3'b110;
  localparam branch_op_t BR_GEU = 3'b111;

endpackage

`default_nettype wire

// ==== src/exu_pkg.sv ====
`default_nettype none

package exu_pkg;

  // one decoded instruction from decode.
  typedef struct packed {
    riscv_pkg::reg_idx_t   rd;
    riscv_pkg::reg_idx_t   rs1;
    riscv_pkg::reg_idx_t   rs2;
    logic                  jump_en;
    logic                  branch_en;
    logic                  op1_pc_en;
    logic                  op2_imm_en;
    logic                  alu_word;
    riscv_pkg::alu_op_t    alu_op;
    riscv_pkg::branch_op_t branch_op;
    riscv_pkg::xlen_t      pc;
    riscv_pkg::xlen_t      imm;
    riscv_pkg::xlen_t      gpr_data1;
    riscv_pkg::xlen_t      gpr_data2;
    logic                  load_en;
    riscv_pkg::load_op_t   load_op;
    logic                  store_en;
    riscv_pkg::store_len_t store_len;
    logic                  wb_en;
    riscv_pkg::wb_sel_t    wb_sel;
    logic                  ebreak;
    riscv_pkg::xlen_t      snxt_pc;
  } idu_to_exu_t;

  // forwarded register values, picked over the register file.
  typedef struct packed {
    logic             fw_en1;
    riscv_pkg::xlen_t fw_data1;
    logic             fw_en2;
    riscv_pkg::xlen_t fw_data2;
  } bypass_t;

  // registered stage output toward load/store.
  typedef struct packed {
    riscv_pkg::reg_idx_t   rd;
    riscv_pkg::reg_idx_t   rs1;
    riscv_pkg::reg_idx_t   rs2;
    logic                  jump_en;
    logic                  branch_en;
    logic                  branch_taken;
    riscv_pkg::xlen_t      branch_pc;
    riscv_pkg::xlen_t      alu_result;
    riscv_pkg::xlen_t      store_data;
    riscv_pkg::xlen_t      imm;
    logic                  load_en;
    riscv_pkg::load_op_t   load_op;
    logic                  store_en;
    riscv_pkg::store_len_t store_len;
    logic                  wb_en;
    riscv_pkg::wb_sel_t    wb_sel;
    logic                  ebreak;
    riscv_pkg::xlen_t      snxt_pc;
  } exu_to_lsu_t;

endpackage

`default_nettype wire

// ==== src/operand_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module operand_select (
  input  wire exu_pkg::idu_to_exu_t inst,
  input  wire exu_pkg::bypass_t     bypass,
  output riscv_pkg::xlen_t          op1,
  output riscv_pkg::xlen_t          op2,
  output riscv_pkg::xlen_t          cmp1,
  output riscv_pkg::xlen_t          cmp2
);

  riscv_pkg::xlen_t rs1_val;
  riscv_pkg::xlen_t rs2_val;

  // forwarded data wins over the register file.
  always_comb begin
    if (bypass.fw_en1) begin
      rs1_val = bypass.fw_data1;
    end else begin
      rs1_val = inst.gpr_data1;
    end
    if (bypass.fw_en2) begin
      rs2_val = bypass.fw_data2;
    end else begin
      rs2_val = inst.gpr_data2;
    end
  end

  // pc and immediate only replace the alu side.
  always_comb begin
    if (inst.op1_pc_en) begin
      op1 = inst.pc;
    end else begin
      op1 = rs1_val;
    end
    if (inst.op2_imm_en) begin
      op2 = inst.imm;
    end else begin
      op2 = rs2_val;
    end
  end

  // branches compare registers even when the alu computes pc + imm.
  assign cmp1 = rs1_val;
  assign cmp2 = rs2_val;

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module alu (
  input  wire riscv_pkg::xlen_t   op1,
  input  wire riscv_pkg::xlen_t   op2,
  input  wire riscv_pkg::alu_op_t alu_op,
  input  wire                     alu_word,
  output riscv_pkg::xlen_t        alu_result
);

  logic [riscv_pkg::SHAMT_W-1:0]      shamt;
  logic [riscv_pkg::SHAMT_WORD_W-1:0] shamt_w;
  logic [31:0]                        a_w;
  logic [31:0]                        b_w;
  logic                               lt_s;
  logic                               lt_u;
  logic                               lt_s_w;
  logic                               lt_u_w;
  riscv_pkg::xlen_t                   full_res;
  logic [31:0]                        word_res;

  assign shamt   = op2[riscv_pkg::SHAMT_W-1:0];
  assign shamt_w = op2[riscv_pkg::SHAMT_WORD_W-1:0];
  assign a_w     = op1[31:0];
  assign b_w     = op2[31:0];

  assign lt_s   = $signed(op1) < $signed(op2);
  assign lt_u   = op1 < op2;
  assign lt_s_w = $signed(a_w) < $signed(b_w);
  assign lt_u_w = a_w < b_w;

  // full 64-bit forms.
  always_comb begin
    case (alu_op)
      riscv_pkg::ALU_ADD: begin
        full_res = op1 + op2;
      end
      riscv_pkg::ALU_SUB: begin
        full_res = op1 - op2;
      end
      riscv_pkg::ALU_SLL: begin
        full_res = op1 << shamt;
      end
      riscv_pkg::ALU_SLT: begin
        full_res = {{(riscv_pkg::XLEN-1){1'b0}}, lt_s};
      end
      riscv_pkg::ALU_SLTU: begin
        full_res = {{(riscv_pkg::XLEN-1){1'b0}}, lt_u};
      end
      riscv_pkg::ALU_XOR:   full_res = op1 ^ op2;
      riscv_pkg::ALU_SRL:   full_res = op1 >> shamt;
      riscv_pkg::ALU_SRA:   full_res = $signed(op1) >>> shamt;
      riscv_pkg::ALU_OR:    full_res = op1 | op2;
      riscv_pkg::ALU_AND:   full_res = op1 & op2;
      riscv_pkg::ALU_PASSB: full_res = op2;
      default:              full_res = '0;
    endcase
  end

  // word forms work on the low 32 bits only.
  always_comb begin
    case (alu_op)
      riscv_pkg::ALU_ADD: begin
        word_res = a_w + b_w;
      end
      riscv_pkg::ALU_SUB: begin
        word_res = a_w - b_w;
      end
      riscv_pkg::ALU_SLL: begin
        word_res = a_w << shamt_w;
      end
      riscv_pkg::ALU_SLT: begin
        word_res = {31'd0, lt_s_w};
      end
      riscv_pkg::ALU_SLTU: begin
        word_res = {31'd0, lt_u_w};
      end
      riscv_pkg::ALU_XOR:   word_res = a_w ^ b_w;
      // srlw shifts the zero-extended word, sraw fills from bit 31.
      riscv_pkg::ALU_SRL:   word_res = a_w >> shamt_w;
      riscv_pkg::ALU_SRA:   word_res = $signed(a_w) >>> shamt_w;
      riscv_pkg::ALU_OR:    word_res = a_w | b_w;
      riscv_pkg::ALU_AND:   word_res = a_w & b_w;
      riscv_pkg::ALU_PASSB: word_res = b_w;
      default:              word_res = '0;
    endcase
  end

  // sign extend bit 31 for the W forms.
  assign alu_result = alu_word ? {{32{word_res[31]}}, word_res} : full_res;

endmodule

`default_nettype wire

// ==== src/branch_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module branch_unit (
  input  wire riscv_pkg::xlen_t      cmp1,
  input  wire riscv_pkg::xlen_t      cmp2,
  input  wire riscv_pkg::xlen_t      pc,
  input  wire riscv_pkg::xlen_t      imm,
  input  wire                        branch_en,
  input  wire riscv_pkg::branch_op_t branch_op,
  output logic                       branch_taken,
  output riscv_pkg::xlen_t           branch_pc
);

  logic eq;
  logic lt_s;
  logic lt_u;
  logic cond;

  assign eq   = cmp1 == cmp2;
  assign lt_s = $signed(cmp1) < $signed(cmp2);
  assign lt_u = cmp1 < cmp2;

  always_comb begin
    case (branch_op)
      riscv_pkg::BR_EQ:  cond = eq;
      riscv_pkg::BR_NE:  cond = ~eq;
      riscv_pkg::BR_LT:  cond = lt_s;
      riscv_pkg::BR_GE:  cond = ~lt_s;
      riscv_pkg::BR_LTU: cond = lt_u;
      riscv_pkg::BR_GEU: cond = ~lt_u;
      default:           cond = 1'b0;
    endcase
  end

  // non-branch instructions never report taken.
  assign branch_taken = branch_en & cond;

  // target is formed every cycle, jal uses it too.
  assign branch_pc = pc + imm;

endmodule

`default_nettype wire

// ==== src/exu_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_ctrl (
  input  wire                       clk,
  input  wire                       rstn,
  input  wire                       in_valid,
  output logic                      in_ready,
  input  wire                       flush,
  input  wire exu_pkg::idu_to_exu_t inst,
  input  wire riscv_pkg::xlen_t     alu_result,
  input  wire                       branch_taken,
  input  wire riscv_pkg::xlen_t     branch_pc,
  input  wire riscv_pkg::xlen_t     store_data,
  output logic                      out_valid,
  input  wire                       out_ready,
  output exu_pkg::exu_to_lsu_t      result
);

  exu_pkg::exu_to_lsu_t next_entry;
  logic                 in_fire;
  logic                 out_fire;
  logic                 keep;

  // free when empty or when the held entry leaves this cycle.
  assign in_ready = ~out_valid | out_ready;
  assign in_fire  = in_valid & in_ready;
  assign out_fire = out_valid & out_ready;

  // a flushed instruction becomes a bubble.
  assign keep = ~flush;

  always_comb begin
    next_entry.rd           = inst.rd;
    next_entry.rs1          = inst.rs1;
    next_entry.rs2          = inst.rs2;
    next_entry.jump_en      = inst.jump_en & keep;
    next_entry.branch_en    = inst.branch_en & keep;
    next_entry.branch_taken = branch_taken & keep;
    next_entry.branch_pc    = branch_pc;
    next_entry.alu_result   = alu_result;
    next_entry.store_data   = store_data;
    next_entry.imm          = inst.imm;
    next_entry.load_en      = inst.load_en & keep;
    next_entry.load_op      = inst.load_op;
    next_entry.store_en     = inst.store_en & keep;
    next_entry.store_len    = inst.store_len;
    next_entry.wb_en        = inst.wb_en & keep;
    next_entry.wb_sel       = inst.wb_sel;
    next_entry.ebreak       = inst.ebreak & keep;
    next_entry.snxt_pc      = inst.snxt_pc;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      out_valid           <= 1'b0;
      result.jump_en      <= 1'b0;
      result.branch_en    <= 1'b0;
      result.branch_taken <= 1'b0;
      result.load_en      <= 1'b0;
      result.store_en     <= 1'b0;
      result.wb_en        <= 1'b0;
      result.ebreak       <= 1'b0;
    end else if (in_fire) begin
      // load covers the case of a handoff in the same cycle.
      out_valid <= 1'b1;
      result    <= next_entry;
    end else if (out_fire) begin
      out_valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== src/exu_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_stage (
  input  wire                       clk,
  input  wire                       rstn,
  input  wire                       in_valid,
  output logic                      in_ready,
  input  wire                       flush,
  input  wire exu_pkg::idu_to_exu_t inst,
  input  wire exu_pkg::bypass_t     bypass,
  output logic                      out_valid,
  input  wire                       out_ready,
  output exu_pkg::exu_to_lsu_t      result
);

  riscv_pkg::xlen_t op1;
  riscv_pkg::xlen_t op2;
  riscv_pkg::xlen_t cmp1;
  riscv_pkg::xlen_t cmp2;
  riscv_pkg::xlen_t alu_result;
  riscv_pkg::xlen_t branch_pc;
  logic             branch_taken;

  operand_select u_operand_select (
    .inst   (inst),
    .bypass (bypass),
    .op1    (op1),
    .op2    (op2),
    .cmp1   (cmp1),
    .cmp2   (cmp2)
  );

  alu u_alu (
    .op1        (op1),
    .op2        (op2),
    .alu_op     (inst.alu_op),
    .alu_word   (inst.alu_word),
    .alu_result (alu_result)
  );

  branch_unit u_branch_unit (
    .cmp1         (cmp1),
    .cmp2         (cmp2),
    .pc           (inst.pc),
    .imm          (inst.imm),
    .branch_en    (inst.branch_en),
    .branch_op    (inst.branch_op),
    .branch_taken (branch_taken),
    .branch_pc    (branch_pc)
  );

  // store data is rs2 after bypass, never the immediate.
  exu_ctrl u_exu_ctrl (
    .clk          (clk),
    .rstn         (rstn),
    .in_valid     (in_valid),
    .in_ready     (in_ready),
    .flush        (flush),
    .inst         (inst),
    .alu_result   (alu_result),
    .branch_taken (branch_taken),
    .branch_pc    (branch_pc),
    .store_data   (cmp2),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .result       (result)
  );

endmodule

`default_nettype wire

// ==== testbench/exu_stage_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_stage_checker (
  input wire                       clk,
  input wire                       rstn,
  input wire                       in_valid,
  input wire                       in_ready,
  input wire                       flush,
  input wire                       out_valid,
  input wire                       out_ready,
  input wire exu_pkg::exu_to_lsu_t result
);

  int errors = 0;

  // the stage register comes up empty.
  reset_empty: assert property (@(posedge clk) !rstn |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      errors++;
    end

  // a stalled entry holds.
  hold_stalled: assert property (@(posedge clk) disable iff (!rstn)
    out_valid && !out_ready |=> out_valid && $stable(result))
    else begin
      $error("result changed while stalled");
      errors++;
    end

  ready_rule: assert property (@(posedge clk) disable iff (!rstn)
    in_ready == (!out_valid || out_ready))
    else begin
      $error("in_ready does not follow out_valid and out_ready");
      errors++;
    end

  // flushed transfer leaves a bubble
  flush_bubble: assert property (@(posedge clk) disable iff (!rstn)
    in_valid && in_ready && flush |=> !(result.jump_en || result.branch_en ||
      result.branch_taken || result.load_en || result.store_en || result.wb_en ||
      result.ebreak))
    else begin
      $error("side-effect enable set after a flushed transfer");
      errors++;
    end

endmodule

`default_nettype wire

// ==== testbench/exu_stage_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module exu_stage_tb;

  typedef struct packed {
    exu_pkg::idu_to_exu_t inst;
    exu_pkg::bypass_t     bypass;
    logic                 flush;
    exu_pkg::exu_to_lsu_t want;
  } row_t;

  logic                 clk;
  logic                 rstn;
  logic                 in_valid;
  logic                 in_ready;
  logic                 flush;
  exu_pkg::idu_to_exu_t inst;
  exu_pkg::bypass_t     bypass;
  logic                 out_valid;
  logic                 out_ready;
  exu_pkg::exu_to_lsu_t result;
  row_t                 table_q[$];
  exu_pkg::exu_to_lsu_t exp_q[$];
  int                   idx_q[$];
  int                   pass_count;
  int                   fail_count;
  logic                 stall_en;
  logic                 row_ok;
  logic                 row_timeout;

  exu_stage UUT (.*);

  bind exu_stage exu_stage_checker u_checker (.*);

  always #50 clk = ~clk;

  // alu reference, word forms sign-extend bit 31.
  function automatic riscv_pkg::xlen_t ref_alu(input riscv_pkg::xlen_t a, b,
                                               input riscv_pkg::alu_op_t op, input logic word);
    int     w;
    longint f;
    if (word) begin
      case (op)
        riscv_pkg::ALU_ADD:   w = a[31:0] + b[31:0];
        riscv_pkg::ALU_SUB:   w = a[31:0] - b[31:0];
        riscv_pkg::ALU_SLL:   w = a[31:0] << b[4:0];
        riscv_pkg::ALU_SLT:   w = int'(a[31:0]) < int'(b[31:0]);
        riscv_pkg::ALU_SLTU:  w = a[31:0] < b[31:0];
        riscv_pkg::ALU_XOR:   w = a[31:0] ^ b[31:0];
        riscv_pkg::ALU_SRL:   w = a[31:0] >> b[4:0];
        riscv_pkg::ALU_SRA:   w = int'(a[31:0]) >>> b[4:0];
        riscv_pkg::ALU_OR:    w = a[31:0] | b[31:0];
        riscv_pkg::ALU_AND:   w = a[31:0] & b[31:0];
        riscv_pkg::ALU_PASSB: w = b[31:0];
        default:              w = 0;
      endcase
      return longint'(w);
    end
    case (op)
      riscv_pkg::ALU_ADD:   f = a + b;
      riscv_pkg::ALU_SUB:   f = a - b;
      riscv_pkg::ALU_SLL:   f = a << b[5:0];
      riscv_pkg::ALU_SLT:   f = longint'(a) < longint'(b);
      riscv_pkg::ALU_SLTU:  f = a < b;
      riscv_pkg::ALU_XOR:   f = a ^ b;
      riscv_pkg::ALU_SRL:   f = a >> b[5:0];
      riscv_pkg::ALU_SRA:   f = longint'(a) >>> b[5:0];
      riscv_pkg::ALU_OR:    f = a | b;
      riscv_pkg::ALU_AND:   f = a & b;
      riscv_pkg::ALU_PASSB: f = b;
      default:              f = 0;
    endcase
    return f;
  endfunction

  function automatic logic ref_branch(input riscv_pkg::xlen_t a, b,
                                      input riscv_pkg::branch_op_t op);
    case (op)
      riscv_pkg::BR_EQ:  return a == b;
      riscv_pkg::BR_NE:  return a != b;
      riscv_pkg::BR_LT:  return longint'(a) < longint'(b);
      riscv_pkg::BR_GE:  return longint'(a) >= longint'(b);
      riscv_pkg::BR_LTU: return a < b;
      riscv_pkg::BR_GEU: return a >= b;
      default:           return 1'b0;
    endcase
  endfunction

  // random fields, no branch and no pc/imm override.
  function automatic exu_pkg::idu_to_exu_t rand_inst();
    exu_pkg::idu_to_exu_t i;
    i = {$urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom, $urandom,
         $urandom, $urandom, $urandom, $urandom};
    i.branch_en  = 1'b0;
    i.op1_pc_en  = 1'b0;
    i.op2_imm_en = 1'b0;
    return i;
  endfunction

  task automatic add_row(input exu_pkg::idu_to_exu_t i, input exu_pkg::bypass_t b,
                         input logic fl);
    row_t             r;
    riscv_pkg::xlen_t rs1;
    riscv_pkg::xlen_t rs2;
    rs1 = b.fw_en1 ? b.fw_data1 : i.gpr_data1;
    rs2 = b.fw_en2 ? b.fw_data2 : i.gpr_data2;
    r.inst   = i;
    r.bypass = b;
    r.flush  = fl;
    r.want   = '{rd: i.rd, rs1: i.rs1, rs2: i.rs2, jump_en: i.jump_en & ~fl,
                 branch_en: i.branch_en & ~fl,
                 branch_taken: i.branch_en & ~fl & ref_branch(rs1, rs2, i.branch_op),
                 branch_pc: i.pc + i.imm,
                 alu_result: ref_alu(i.op1_pc_en ? i.pc : rs1, i.op2_imm_en ? i.imm : rs2,
                                     i.alu_op, i.alu_word),
                 store_data: rs2, imm: i.imm, load_en: i.load_en & ~fl, load_op: i.load_op,
                 store_en: i.store_en & ~fl, store_len: i.store_len, wb_en: i.wb_en & ~fl,
                 wb_sel: i.wb_sel, ebreak: i.ebreak & ~fl, snxt_pc: i.snxt_pc};
    table_q.push_back(r);
  endtask

  task automatic build_table();
    exu_pkg::idu_to_exu_t  i;
    exu_pkg::bypass_t      b;
    riscv_pkg::xlen_t      av[4];
    riscv_pkg::xlen_t      bv[6];
    riscv_pkg::xlen_t      c1[4];
    riscv_pkg::xlen_t      c2[4];
    riscv_pkg::branch_op_t bops[6];
    av   = '{64'h8000_0000_0000_0000, 64'h0000_0000_8000_0001, 64'hffff_ffff_ffff_ffff,
             64'h1234_5678_9abc_def0};
    bv   = '{64'd0, 64'd31, 64'd32, 64'd63, 64'h7fff_ffff_ffff_ffff, 64'hffff_ffff_8000_0000};
    c1   = '{64'd5, 64'hffff_ffff_ffff_ffff, 64'd1, 64'd2};
    c2   = '{64'd5, 64'd1, 64'hffff_ffff_ffff_ffff, 64'd7};
    bops = '{riscv_pkg::BR_EQ, riscv_pkg::BR_NE, riscv_pkg::BR_LT, riscv_pkg::BR_GE,
             riscv_pkg::BR_LTU, riscv_pkg::BR_GEU};
    // every op code in full and word form over sign and shift edges.
    for (int op = 0; op < 12; op++) begin
      for (int w = 0; w < 2; w++) begin
        for (int j = 0; j < 6; j++) begin
          i = rand_inst();
          i.alu_op    = op;
          i.alu_word  = w;
          i.gpr_data1 = av[(j + op) % 4];
          i.gpr_data2 = bv[j];
          add_row(i, '0, 1'b0);
        end
      end
    end
    // lui, then auipc.
    i = rand_inst();
    i.op2_imm_en = 1'b1;
    i.alu_op     = riscv_pkg::ALU_PASSB;
    i.imm        = 64'hffff_ffff_abcd_e000;
    add_row(i, '0, 1'b0);
    i.op1_pc_en = 1'b1;
    i.alu_op    = riscv_pkg::ALU_ADD;
    add_row(i, '0, 1'b0);
    for (int k = 0; k < 16; k++) begin
      i = rand_inst();
      b = {$urandom, $urandom, $urandom, $urandom, $urandom};
      b.fw_en1     = k[0];
      b.fw_en2     = k[1];
      i.op1_pc_en  = k[2];
      i.op2_imm_en = k[3];
      i.alu_op     = riscv_pkg::ALU_SUB;
      add_row(i, b, 1'b0);
    end
    // first half with branch_en low.
    for (int k = 0; k < 48; k++) begin
      i = rand_inst();
      i.branch_en  = k >= 24;
      i.branch_op  = bops[k % 6];
      i.gpr_data1  = c1[(k / 6) % 4];
      i.gpr_data2  = c2[(k / 6) % 4];
      i.op1_pc_en  = 1'b1;
      i.op2_imm_en = 1'b1;
      add_row(i, '0, 1'b0);
    end
    for (int k = 0; k < 4; k++) begin
      i = rand_inst();
      {i.jump_en, i.branch_en, i.load_en, i.store_en, i.wb_en, i.ebreak} = 6'b111111;
      i.branch_op = riscv_pkg::BR_EQ;
      i.gpr_data2 = i.gpr_data1;
      add_row(i, '0, 1'b1);
    end
    for (int k = 0; k < 40; k++) begin
      i = rand_inst();
      b = {$urandom, $urandom, $urandom, $urandom, $urandom};
      {i.branch_en, i.op1_pc_en, i.op2_imm_en} = $urandom;
      add_row(i, b, $urandom_range(9) == 0);
    end
  endtask

  task automatic check_field(input int row, input string name, input logic [511:0] got,
                             input logic [511:0] want);
    assert (got === want) else begin
      $display("[FAIL] row %0d %s got %0h expected %0h", row, name, got, want);
      row_ok = 1'b0;
    end
  endtask

  task automatic check_output();
    exu_pkg::exu_to_lsu_t want;
    int                   row;
    assert (exp_q.size() > 0) else begin
      $display("a result was handed off with no instruction outstanding");
      fail_count++;
    end
    if (exp_q.size() > 0) begin
      want   = exp_q.pop_front();
      row    = idx_q.pop_front();
      row_ok = 1'b1;
      check_field(row, "alu_result", result.alu_result, want.alu_result);
      check_field(row, "branch_taken", result.branch_taken, want.branch_taken);
      check_field(row, "branch_pc", result.branch_pc, want.branch_pc);
      check_field(row, "store_data", result.store_data, want.store_data);
      check_field(row, "result", result, want);
      if (row_ok) begin
        pass_count++;
        $display("row %0d ok", row);
      end else begin
        fail_count++;
        $display("row %0d mismatch", row);
      end
    end
  endtask

  // about 30 % stall cycles once stall_en is set.
  task automatic drive_output();
    forever begin
      @(negedge clk);
      out_ready = stall_en ? ($urandom_range(99) >= 30) : 1'b1;
      #1;
      if (out_valid && out_ready) begin
        check_output();
      end
    end
  endtask

  task automatic end_run(input logic timed_out);
    $display("rows passed %0d failed %0d checker errors %0d", pass_count, fail_count,
             UUT.u_checker.errors);
    if (fail_count == 0 && UUT.u_checker.errors == 0 && !timed_out) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  endtask

  // starts on a falling edge, returns on the falling edge after the transfer.
  task automatic send_row(input int row);
    int waited;
    in_valid = 1'b1;
    inst     = table_q[row].inst;
    bypass   = table_q[row].bypass;
    flush    = table_q[row].flush;
    waited   = 0;
    #1;
    while (!in_ready && waited < 50) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!in_ready) begin
      $display("timeout: in_ready stayed low for 50 cycles at row %0d", row);
      in_valid    = 1'b0;
      row_timeout = 1'b1;
    end else begin
      exp_q.push_back(table_q[row].want);
      idx_q.push_back(row);
      @(negedge clk);
      in_valid = 1'b0;
    end
  endtask

  initial begin
    int waited;
    void'($urandom(32'h76892391));
    clk         = 1'b0;
    rstn        = 1'b0;
    in_valid    = 1'b0;
    flush       = 1'b0;
    inst        = '0;
    bypass      = '0;
    out_ready   = 1'b0;
    stall_en    = 1'b0;
    row_timeout = 1'b0;
    pass_count  = 0;
    fail_count  = 0;
    build_table();
    fork
      drive_output();
    join_none
    repeat (4) @(negedge clk);
    rstn = 1'b1;
    #1;
    assert (!out_valid && in_ready) else begin
      $display("stage is not empty and ready after reset");
      fail_count++;
    end
    assert (!(result.jump_en || result.branch_en || result.branch_taken || result.load_en ||
              result.store_en || result.wb_en || result.ebreak)) else begin
      $display("a side-effect enable in result is set after reset");
      fail_count++;
    end
    @(negedge clk);
    send_row(0);
    #1;
    assert (out_valid) else begin
      $display("first result was not valid one cycle after its transfer");
      fail_count++;
    end
    stall_en = 1'b1;
    @(negedge clk);
    for (int r = 1; r < table_q.size() && !row_timeout; r++) begin
      repeat (($urandom_range(3) == 0) ? $urandom_range(3, 1) : 0) @(negedge clk);
      send_row(r);
    end
    waited = 0;
    while (exp_q.size() > 0 && waited < 50) begin
      @(negedge clk);
      waited++;
    end
    repeat (2) @(negedge clk);
    if (exp_q.size() > 0) begin
      $display("timeout: %0d results never came out", exp_q.size());
    end
    end_run(row_timeout || exp_q.size() > 0);
  end

endmodule

`default_nettype wire

// ==== exu_stage.f ====
src/riscv_pkg.sv
src/exu_pkg.sv
src/operand_select.sv
src/alu.sv
src/branch_unit.sv
src/exu_ctrl.sv
src/exu_stage.sv
testbench/exu_stage_checker.sv
testbench/exu_stage_tb.sv

// ==== Bender.yml ====
package:
  name: exu_stage

sources:
  - src/riscv_pkg.sv
  - src/exu_pkg.sv
  - src/operand_select.sv
  - src/alu.sv
  - src/branch_unit.sv
  - src/exu_ctrl.sv
  - src/exu_stage.sv
  - target: test
    files:
      - testbench/exu_stage_checker.sv
      - testbench/exu_stage_tb.sv
